//--- hdl/issue_pkg.sv
package issue_pkg;

    // widths
    localparam int REG_W   = 5;
    localparam int PC_W    = 64;
    localparam int CLS_W   = 6;
    localparam int N_UNITS = 3;

    // architectural register number, x0 is never a tracked destination
    typedef logic [REG_W-1:0]   reg_addr_t;

    typedef logic [PC_W-1:0]    pc_t;

    // one-hot instruction class, bit positions below
    typedef logic [CLS_W-1:0]   inst_class_t;

    // one-hot unit choice, all zero means no unit
    typedef logic [N_UNITS-1:0] unit_sel_t;

    // class bits
    localparam int CLS_MULDIV = 0;
    localparam int CLS_LDST   = 1;
    localparam int CLS_CSR    = 2;
    localparam int CLS_JUMP   = 3;
    localparam int CLS_ALU    = 4;
    localparam int CLS_TRAP   = 5;

    // unit indices
    localparam int U_ALU0 = 0;
    localparam int U_ALU1 = 1;
    localparam int U_MMU  = 2;

endpackage

//--- hdl/hazard_check.sv
`timescale 1ns/1ps

module hazard_check
    import issue_pkg::*;
(
    input  logic               valid,
    input  pc_t                pc,
    input  reg_addr_t          rs1,
    input  logic               rs1_en,
    input  reg_addr_t          rs2,
    input  logic               rs2_en,
    input  reg_addr_t          rd,
    input  logic               rd_en,

    input  logic               other_valid,
    input  pc_t                other_pc,
    input  reg_addr_t          other_rd,
    input  logic               other_rd_en,

    input  logic [N_UNITS-1:0] unit_busy,
    input  reg_addr_t          unit_dest0,
    input  reg_addr_t          unit_dest1,
    input  reg_addr_t          unit_dest2,

    output logic               data_stall
);

    reg_addr_t unit_dest [N_UNITS];
    logic      unit_hit;
    logic      younger;
    logic      pair_hit;

    assign unit_dest[U_ALU0] = unit_dest0;
    assign unit_dest[U_ALU1] = unit_dest1;
    assign unit_dest[U_MMU]  = unit_dest2;

    // an enabled field hits a destination, x0 never hits
    function automatic logic reg_hit(reg_addr_t a, logic a_en, reg_addr_t d);
        return a_en && (d != '0) && (a == d);
    endfunction

    // any enabled field of this slot against one destination
    function automatic logic slot_hit(reg_addr_t d);
        return reg_hit(rs1, rs1_en, d) ||
               reg_hit(rs2, rs2_en, d) ||
               reg_hit(rd, rd_en, d);
    endfunction

    // RAW and WAW against units still in flight
    always_comb begin
        unit_hit = 1'b0;
        for (int i = 0; i < N_UNITS; i++) begin
            if (unit_busy[i] && slot_hit(unit_dest[i])) begin
                unit_hit = 1'b1;
            end
        end
    end

    // the higher pc is the younger of the pair
    assign younger = other_valid && (pc > other_pc);

    // younger slot also waits on the older slot's destination
    assign pair_hit = younger && other_rd_en && slot_hit(other_rd);

    assign data_stall = valid && (unit_hit || pair_hit);

endmodule

//--- hdl/unit_tracker.sv
`timescale 1ns/1ps

module unit_tracker
    import issue_pkg::*;
#(
    parameter int LAT   = 2,
    parameter int CNT_W = 3
) (
    input  logic      clk,
    input  logic      arst_n,

    input  logic      alloc,
    input  reg_addr_t alloc_rd,
    input  logic      alloc_rd_en,

    output logic      busy,
    output reg_addr_t dest
);

    localparam logic [CNT_W-1:0] LOAD_VAL = CNT_W'(LAT);

    logic [CNT_W-1:0] cnt;
    reg_addr_t        dest_q;

    // remaining busy cycles
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else if (alloc) begin
            cnt <= LOAD_VAL;
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    // x0 or no writeback leaves nothing to track
    always_ff @(posedge clk) begin
        if (alloc) begin
            if (alloc_rd_en && (alloc_rd != '0)) begin
                dest_q <= alloc_rd;
            end else begin
                dest_q <= '0;
            end
        end
    end

    assign busy = (cnt != '0);

    // dest only meaningful while the unit is busy
    assign dest = busy ? dest_q : '0;

endmodule

//--- hdl/issue_arbiter.sv
`timescale 1ns/1ps

module issue_arbiter
    import issue_pkg::*;
(
    input  logic               clk,
    input  logic               arst_n,

    input  logic               s1_valid,
    input  logic               s2_valid,
    input  pc_t                s1_pc,
    input  pc_t                s2_pc,
    input  inst_class_t        s1_class,
    input  inst_class_t        s2_class,
    input  reg_addr_t          s1_rd,
    input  reg_addr_t          s2_rd,
    input  logic               s1_rd_en,
    input  logic               s2_rd_en,
    input  logic               stall_in1,
    input  logic               stall_in2,
    input  logic [N_UNITS-1:0] unit_busy,
    input  logic               commit_stop,
    input  logic               timer_intr,

    output logic               stall1,
    output logic               stall2,
    output logic               flush1,
    output logic               flush2,
    output logic               issue1,
    output logic               issue2,
    output unit_sel_t          unit1,
    output unit_sel_t          unit2,
    output logic [N_UNITS-1:0] alloc,
    output reg_addr_t          alloc_rd0,
    output reg_addr_t          alloc_rd1,
    output reg_addr_t          alloc_rd2,
    output logic [N_UNITS-1:0] alloc_rd_en,
    output logic               trap_valid,
    output pc_t                trap_pc
);

    logic        swap;
    logic        o_valid;
    pc_t         o_pc;
    inst_class_t o_class;
    logic        o_hz;
    logic        y_valid;
    inst_class_t y_class;
    logic        y_hz;
    logic        trap_take;
    logic        jump_flush;
    unit_sel_t   free_all;
    unit_sel_t   free_rest;
    unit_sel_t   o_unit;
    unit_sel_t   y_unit;
    logic        o_stall;
    logic        y_stall;
    logic        y_flush;
    unit_sel_t   unit1_c;
    unit_sel_t   unit2_c;

    // free unit for a class, lowest numbered alu first
    function automatic unit_sel_t pick_unit(inst_class_t cls, unit_sel_t free);
        unit_sel_t alu_pick;
        unit_sel_t sel;
        alu_pick = '0;
        if (free[U_ALU0]) begin
            alu_pick[U_ALU0] = 1'b1;
        end else if (free[U_ALU1]) begin
            alu_pick[U_ALU1] = 1'b1;
        end
        sel = '0;
        if (cls[CLS_LDST]) begin
            sel[U_MMU] = free[U_MMU];
        end else if (cls[CLS_CSR]) begin
            sel[U_ALU0] = free[U_ALU0];
        end else if (cls[CLS_MULDIV] || cls[CLS_JUMP] || cls[CLS_ALU]) begin
            sel = alu_pick;
        end
        // trap class has no unit of its own
        return sel;
    endfunction

    // slot 2 is older only when its pc is strictly lower
    assign swap = s2_valid && (!s1_valid || (s2_pc < s1_pc));

    assign o_valid = swap ? s2_valid  : s1_valid;
    assign o_pc    = swap ? s2_pc     : s1_pc;
    assign o_class = swap ? s2_class  : s1_class;
    assign o_hz    = swap ? stall_in2 : stall_in1;
    assign y_valid = swap ? s1_valid  : s2_valid;
    assign y_class = swap ? s1_class  : s2_class;
    assign y_hz    = swap ? stall_in1 : stall_in2;

    // trap waits until the pipeline has drained
    assign trap_take = o_valid && (timer_intr || o_class[CLS_TRAP]) && (unit_busy == '0);

    assign free_all = ~unit_busy;

    always_comb begin
        o_unit = '0;
        if (o_valid && !o_hz && !commit_stop && !trap_take) begin
            o_unit = pick_unit(o_class, free_all);
        end
    end

    assign jump_flush = (o_unit != '0) && o_class[CLS_JUMP];
    assign free_rest  = free_all & ~o_unit;

    always_comb begin
        y_unit = '0;
        if (y_valid && !y_hz && !commit_stop && !trap_take && !jump_flush) begin
            y_unit = pick_unit(y_class, free_rest);
        end
    end

    assign o_stall = o_valid && !trap_take && (o_unit == '0);
    assign y_flush = y_valid && (trap_take || jump_flush);
    assign y_stall = y_valid && !y_flush && (y_unit == '0);

    // back to slot order
    assign unit1_c = swap ? y_unit  : o_unit;
    assign unit2_c = swap ? o_unit  : y_unit;
    assign stall1  = swap ? y_stall : o_stall;
    assign stall2  = swap ? o_stall : y_stall;
    assign flush1  = swap ? y_flush : (o_valid && trap_take);
    assign flush2  = swap ? (o_valid && trap_take) : y_flush;

    // trackers load on the same edge as the issue registers
    assign alloc       = unit1_c | unit2_c;
    assign alloc_rd0   = unit1_c[U_ALU0] ? s1_rd : s2_rd;
    assign alloc_rd1   = unit1_c[U_ALU1] ? s1_rd : s2_rd;
    assign alloc_rd2   = unit1_c[U_MMU]  ? s1_rd : s2_rd;
    assign alloc_rd_en = (unit1_c & {N_UNITS{s1_rd_en}}) | (unit2_c & {N_UNITS{s2_rd_en}});

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            issue1     <= 1'b0;
            issue2     <= 1'b0;
            unit1      <= '0;
            unit2      <= '0;
            trap_valid <= 1'b0;
            trap_pc    <= '0;
        end else begin
            issue1     <= (unit1_c != '0);
            issue2     <= (unit2_c != '0);
            unit1      <= unit1_c;
            unit2      <= unit2_c;
            trap_valid <= trap_take;
            if (trap_take) begin
                trap_pc <= o_pc;
            end
        end
    end

endmodule

//--- hdl/issue_scoreboard.sv
`timescale 1ns/1ps

module issue_scoreboard
    import issue_pkg::*;
#(
    parameter int ALU_LAT = 2,
    parameter int MMU_LAT = 4,
    parameter int CNT_W   = 3
) (
    input  logic        clk,
    input  logic        arst_n,

    input  logic        s1_valid,
    input  pc_t         s1_pc,
    input  inst_class_t s1_class,
    input  reg_addr_t   s1_rs1,
    input  logic        s1_rs1_en,
    input  reg_addr_t   s1_rs2,
    input  logic        s1_rs2_en,
    input  reg_addr_t   s1_rd,
    input  logic        s1_rd_en,

    input  logic        s2_valid,
    input  pc_t         s2_pc,
    input  inst_class_t s2_class,
    input  reg_addr_t   s2_rs1,
    input  logic        s2_rs1_en,
    input  reg_addr_t   s2_rs2,
    input  logic        s2_rs2_en,
    input  reg_addr_t   s2_rd,
    input  logic        s2_rd_en,

    input  logic        commit_stop,
    input  logic        timer_intr,

    output logic        stall1,
    output logic        stall2,
    output logic        flush1,
    output logic        flush2,
    output logic        issue1,
    output logic        issue2,
    output unit_sel_t   unit1,
    output unit_sel_t   unit2,
    output logic        trap_valid,
    output pc_t         trap_pc
);

    logic [N_UNITS-1:0] unit_busy;
    reg_addr_t          unit_dest0;
    reg_addr_t          unit_dest1;
    reg_addr_t          unit_dest2;
    logic               data_stall1;
    logic               data_stall2;
    logic [N_UNITS-1:0] alloc;
    reg_addr_t          alloc_rd0;
    reg_addr_t          alloc_rd1;
    reg_addr_t          alloc_rd2;
    logic [N_UNITS-1:0] alloc_rd_en;

    hazard_check u_hazard1 (
        .valid       (s1_valid),
        .pc          (s1_pc),
        .rs1         (s1_rs1),
        .rs1_en      (s1_rs1_en),
        .rs2         (s1_rs2),
        .rs2_en      (s1_rs2_en),
        .rd          (s1_rd),
        .rd_en       (s1_rd_en),
        .other_valid (s2_valid),
        .other_pc    (s2_pc),
        .other_rd    (s2_rd),
        .other_rd_en (s2_rd_en),
        .unit_busy   (unit_busy),
        .unit_dest0  (unit_dest0),
        .unit_dest1  (unit_dest1),
        .unit_dest2  (unit_dest2),
        .data_stall  (data_stall1)
    );

    hazard_check u_hazard2 (
        .valid       (s2_valid),
        .pc          (s2_pc),
        .rs1         (s2_rs1),
        .rs1_en      (s2_rs1_en),
        .rs2         (s2_rs2),
        .rs2_en      (s2_rs2_en),
        .rd          (s2_rd),
        .rd_en       (s2_rd_en),
        .other_valid (s1_valid),
        .other_pc    (s1_pc),
        .other_rd    (s1_rd),
        .other_rd_en (s1_rd_en),
        .unit_busy   (unit_busy),
        .unit_dest0  (unit_dest0),
        .unit_dest1  (unit_dest1),
        .unit_dest2  (unit_dest2),
        .data_stall  (data_stall2)
    );

    issue_arbiter u_arbiter (
        .clk         (clk),
        .arst_n      (arst_n),
        .s1_valid    (s1_valid),
        .s2_valid    (s2_valid),
        .s1_pc       (s1_pc),
        .s2_pc       (s2_pc),
        .s1_class    (s1_class),
        .s2_class    (s2_class),
        .s1_rd       (s1_rd),
        .s2_rd       (s2_rd),
        .s1_rd_en    (s1_rd_en),
        .s2_rd_en    (s2_rd_en),
        .stall_in1   (data_stall1),
        .stall_in2   (data_stall2),
        .unit_busy   (unit_busy),
        .commit_stop (commit_stop),
        .timer_intr  (timer_intr),
        .stall1      (stall1),
        .stall2      (stall2),
        .flush1      (flush1),
        .flush2      (flush2),
        .issue1      (issue1),
        .issue2      (issue2),
        .unit1       (unit1),
        .unit2       (unit2),
        .alloc       (alloc),
        .alloc_rd0   (alloc_rd0),
        .alloc_rd1   (alloc_rd1),
        .alloc_rd2   (alloc_rd2),
        .alloc_rd_en (alloc_rd_en),
        .trap_valid  (trap_valid),
        .trap_pc     (trap_pc)
    );

    unit_tracker #(.LAT(ALU_LAT), .CNT_W(CNT_W)) u_alu0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .alloc       (alloc[U_ALU0]),
        .alloc_rd    (alloc_rd0),
        .alloc_rd_en (alloc_rd_en[U_ALU0]),
        .busy        (unit_busy[U_ALU0]),
        .dest        (unit_dest0)
    );

    unit_tracker #(.LAT(ALU_LAT), .CNT_W(CNT_W)) u_alu1 (
        .clk         (clk),
        .arst_n      (arst_n),
        .alloc       (alloc[U_ALU1]),
        .alloc_rd    (alloc_rd1),
        .alloc_rd_en (alloc_rd_en[U_ALU1]),
        .busy        (unit_busy[U_ALU1]),
        .dest        (unit_dest1)
    );

    unit_tracker #(.LAT(MMU_LAT), .CNT_W(CNT_W)) u_mmu (
        .clk         (clk),
        .arst_n      (arst_n),
        .alloc       (alloc[U_MMU]),
        .alloc_rd    (alloc_rd2),
        .alloc_rd_en (alloc_rd_en[U_MMU]),
        .busy        (unit_busy[U_MMU]),
        .dest        (unit_dest2)
    );

endmodule

//--- tb/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// model of the three units, remaining cycles and tracked destination
int        m_cnt [N_UNITS];
reg_addr_t m_dest [N_UNITS];

// any enabled field of slot i names register d, x0 never matches
function automatic logic slot_uses(int i, reg_addr_t d);
    logic hit;
    hit = 1'b0;
    if (d != '0) begin
        hit = (slot_rs1_en[i] && (slot_rs1[i] == d)) ||
              (slot_rs2_en[i] && (slot_rs2[i] == d)) ||
              (slot_rd_en[i] && (slot_rd[i] == d));
    end
    return hit;
endfunction

function automatic logic data_hazard(int i);
    int   j;
    logic hz;
    j = 1 - i;
    hz = 1'b0;
    for (int u = 0; u < N_UNITS; u++) begin
        if ((m_cnt[u] != 0) && slot_uses(i, m_dest[u])) begin
            hz = 1'b1;
        end
    end
    // the younger slot also waits on its older partner
    if (slot_valid[j] && (slot_pc[i] > slot_pc[j]) && slot_rd_en[j]) begin
        if (slot_uses(i, slot_rd[j])) begin
            hz = 1'b1;
        end
    end
    return slot_valid[i] && hz;
endfunction

function automatic unit_sel_t choose_unit(inst_class_t c, unit_sel_t avail);
    unit_sel_t u;
    u = '0;
    if (c[CLS_LDST]) begin
        u[U_MMU] = avail[U_MMU];
    end else if (c[CLS_CSR]) begin
        u[U_ALU0] = avail[U_ALU0];
    end else if (c[CLS_MULDIV] || c[CLS_JUMP] || c[CLS_ALU]) begin
        if (avail[U_ALU0]) begin
            u[U_ALU0] = 1'b1;
        end else if (avail[U_ALU1]) begin
            u[U_ALU1] = 1'b1;
        end
    end
    return u;
endfunction

// expected stall, flush, unit and trap for the slots on the inputs now
function automatic void predict_issue();
    int         o;
    int         y;
    unit_sel_t  avail;
    logic [1:0] hz;
    hz[0] = data_hazard(0);
    hz[1] = data_hazard(1);
    // lower pc is older, slot 1 when slot 2 is empty
    o = (slot_valid[1] && (!slot_valid[0] || (slot_pc[1] < slot_pc[0]))) ? 1 : 0;
    y = 1 - o;
    for (int u = 0; u < N_UNITS; u++) begin
        avail[u] = (m_cnt[u] == 0);
    end
    p_stall = '0;
    p_flush = '0;
    p_unit = '0;
    p_trap = slot_valid[o] && (timer_intr || slot_class[o][CLS_TRAP]) && (avail == '1);
    p_trap_pc = slot_pc[o];
    if (p_trap) begin
        p_flush = slot_valid;
    end else if (commit_stop) begin
        p_stall = slot_valid;
    end else begin
        if (slot_valid[o] && !hz[o]) begin
            p_unit[o] = choose_unit(slot_class[o], avail);
        end
        p_stall[o] = slot_valid[o] && (p_unit[o] == '0);
        if ((p_unit[o] != '0) && slot_class[o][CLS_JUMP]) begin
            p_flush[y] = slot_valid[y];
        end else begin
            if (slot_valid[y] && !hz[y]) begin
                p_unit[y] = choose_unit(slot_class[y], avail & ~p_unit[o]);
            end
            p_stall[y] = slot_valid[y] && (p_unit[y] == '0);
        end
    end
endfunction

// state of the units after the coming clock edge
function automatic void advance_units();
    int i;
    for (int u = 0; u < N_UNITS; u++) begin
        if (p_unit[0][u] || p_unit[1][u]) begin
            i = p_unit[0][u] ? 0 : 1;
            m_cnt[u] = (u == U_MMU) ? MMU_LAT : ALU_LAT;
            m_dest[u] = slot_rd_en[i] ? slot_rd[i] : '0;
        end else if (m_cnt[u] != 0) begin
            m_cnt[u] = m_cnt[u] - 1;
        end
    end
endfunction

`endif

//--- tb/tb_issue_scoreboard.sv
`timescale 1ns/1ps

module tb_issue_scoreboard
    import issue_pkg::*;
();

    localparam int ALU_LAT     = 2;
    localparam int MMU_LAT     = 4;
    localparam int N_CYCLES    = 2000;
    localparam int CYCLE_LIMIT = 2 * N_CYCLES + 50;

    logic                  clk;
    logic                  arst_n;
    logic [1:0]            slot_valid;
    pc_t [1:0]             slot_pc;
    inst_class_t [1:0]     slot_class;
    reg_addr_t [1:0]       slot_rs1;
    reg_addr_t [1:0]       slot_rs2;
    reg_addr_t [1:0]       slot_rd;
    logic [1:0]            slot_rs1_en;
    logic [1:0]            slot_rs2_en;
    logic [1:0]            slot_rd_en;
    logic                  commit_stop;
    logic                  timer_intr;
    logic                  stall1;
    logic                  stall2;
    logic                  flush1;
    logic                  flush2;
    logic                  issue1;
    logic                  issue2;
    unit_sel_t             unit1;
    unit_sel_t             unit2;
    logic                  trap_valid;
    pc_t                   trap_pc;

    // predictions for the current cycle and the registered ones due next
    logic [1:0]            p_stall;
    logic [1:0]            p_flush;
    unit_sel_t [1:0]       p_unit;
    logic                  p_trap;
    pc_t                   p_trap_pc;
    logic [1:0]            exp_issue;
    unit_sel_t [1:0]       exp_unit;
    logic                  exp_trap;
    pc_t                   exp_trap_pc;
    int                    cycle_count = 0;
    int unsigned           lcg_state = 81826;

`include "tb_ref_model.svh"

    issue_scoreboard #(.ALU_LAT(ALU_LAT), .MMU_LAT(MMU_LAT), .CNT_W(3)) uut (
        .clk(clk), .arst_n(arst_n),
        .s1_valid(slot_valid[0]), .s1_pc(slot_pc[0]), .s1_class(slot_class[0]),
        .s1_rs1(slot_rs1[0]), .s1_rs1_en(slot_rs1_en[0]),
        .s1_rs2(slot_rs2[0]), .s1_rs2_en(slot_rs2_en[0]),
        .s1_rd(slot_rd[0]), .s1_rd_en(slot_rd_en[0]),
        .s2_valid(slot_valid[1]), .s2_pc(slot_pc[1]), .s2_class(slot_class[1]),
        .s2_rs1(slot_rs1[1]), .s2_rs1_en(slot_rs1_en[1]),
        .s2_rs2(slot_rs2[1]), .s2_rs2_en(slot_rs2_en[1]),
        .s2_rd(slot_rd[1]), .s2_rd_en(slot_rd_en[1]),
        .commit_stop(commit_stop), .timer_intr(timer_intr),
        .stall1(stall1), .stall2(stall2), .flush1(flush1), .flush2(flush2),
        .issue1(issue1), .issue2(issue2), .unit1(unit1), .unit2(unit2),
        .trap_valid(trap_valid), .trap_pc(trap_pc)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return (lcg_state >> 16) & 32'h7fff;
    endfunction

    // mostly alu work and only rarely a trap
    function automatic inst_class_t random_class();
        int unsigned r;
        inst_class_t c;
        r = next_rand() % 16;
        c = '0;
        if (r < 6) begin
            c[CLS_ALU] = 1'b1;
        end else if (r < 8) begin
            c[CLS_MULDIV] = 1'b1;
        end else if (r < 10) begin
            c[CLS_JUMP] = 1'b1;
        end else if (r < 13) begin
            c[CLS_LDST] = 1'b1;
        end else if (r < 15) begin
            c[CLS_CSR] = 1'b1;
        end else begin
            c[CLS_TRAP] = 1'b1;
        end
        return c;
    endfunction

    task automatic report_mismatch(string field, logic [63:0] got, logic [63:0] want);
        $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, field, got, want);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_stall(string field, logic got, logic want);
        if (got !== want) begin
            report_mismatch(field, 64'(got), 64'(want));
        end
    endtask

    task automatic check_unit(string field, unit_sel_t got, unit_sel_t want);
        if (got !== want) begin
            report_mismatch(field, 64'(got), 64'(want));
        end
    endtask

    task automatic check_trap(pc_t got, pc_t want);
        if (got !== want) begin
            report_mismatch("trap_pc", got, want);
        end
    endtask

    task automatic check_reset_state();
        check_stall("issue1", issue1, 1'b0);
        check_stall("issue2", issue2, 1'b0);
        check_stall("stall1", stall1, 1'b0);
        check_stall("stall2", stall2, 1'b0);
        check_stall("flush1", flush1, 1'b0);
        check_stall("flush2", flush2, 1'b0);
        check_stall("trap_valid", trap_valid, 1'b0);
        check_unit("unit1", unit1, '0);
        check_unit("unit2", unit2, '0);
        check_trap(trap_pc, '0);
    endtask

    // a stalled slot is presented again and any other gets a new instruction
    task automatic drive_slots();
        pc_t        new_pc [2];
        logic [1:0] hold;
        hold = slot_valid & p_stall;
        for (int i = 0; i < 2; i++) begin
            new_pc[i] = hold[i] ? slot_pc[i] : 64'h8000_0000 + 4 * (next_rand() % 64);
        end
        if (new_pc[0] == new_pc[1]) begin
            if (hold[1]) begin
                new_pc[0] = new_pc[0] + 4;
            end else begin
                new_pc[1] = new_pc[1] + 4;
            end
        end
        for (int i = 0; i < 2; i++) begin
            if (!hold[i]) begin
                slot_valid[i]  <= (next_rand() % 4) != 0;
                slot_pc[i]     <= new_pc[i];
                slot_class[i]  <= random_class();
                // few registers so that collisions are common
                slot_rs1[i]    <= reg_addr_t'(next_rand() % 6);
                slot_rs2[i]    <= reg_addr_t'(next_rand() % 6);
                slot_rd[i]     <= reg_addr_t'(next_rand() % 6);
                slot_rs1_en[i] <= next_rand() % 2;
                slot_rs2_en[i] <= next_rand() % 2;
                slot_rd_en[i]  <= (next_rand() % 4) != 0;
            end
        end
        commit_stop <= (next_rand() % 12) == 0;
        timer_intr  <= (next_rand() % 16) == 0;
    endtask

    initial begin
        slot_valid = '0;
        slot_pc = '0;
        slot_class = '0;
        slot_rs1 = '0;
        slot_rs2 = '0;
        slot_rd = '0;
        slot_rs1_en = '0;
        slot_rs2_en = '0;
        slot_rd_en = '0;
        commit_stop = 1'b0;
        timer_intr = 1'b0;
        p_stall = '0;
        p_flush = '0;
        p_unit = '0;
        p_trap = 1'b0;
        p_trap_pc = '0;
        exp_issue = '0;
        exp_unit = '0;
        exp_trap = 1'b0;
        exp_trap_pc = '0;
        arst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_reset_state();
        @(posedge clk);
        arst_n <= 1'b1;
        for (int n = 0; n < N_CYCLES; n++) begin
            @(posedge clk);
            drive_slots();
        end
        @(posedge clk);
        slot_valid  <= '0;
        commit_stop <= 1'b0;
        timer_intr  <= 1'b0;
        repeat (4) @(posedge clk);
        $display("NO ERRORS");
        $finish;
    end

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (arst_n) begin
            check_stall("issue1", issue1, exp_issue[0]);
            check_stall("issue2", issue2, exp_issue[1]);
            check_unit("unit1", unit1, exp_unit[0]);
            check_unit("unit2", unit2, exp_unit[1]);
            check_stall("trap_valid", trap_valid, exp_trap);
            check_trap(trap_pc, exp_trap_pc);
            predict_issue();
            check_stall("stall1", stall1, p_stall[0]);
            check_stall("stall2", stall2, p_stall[1]);
            check_stall("flush1", flush1, p_flush[0]);
            check_stall("flush2", flush2, p_flush[1]);
            exp_issue[0] = (p_unit[0] != '0);
            exp_issue[1] = (p_unit[1] != '0);
            exp_unit = p_unit;
            exp_trap = p_trap;
            if (p_trap) begin
                exp_trap_pc = p_trap_pc;
            end
            advance_units();
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the test did not finish", cycle_count);
            $display("ERRORS FOUND");
            $fatal(1, "simulation stopped");
        end
    end

endmodule

//--- files.f
+incdir+tb
hdl/issue_pkg.sv
hdl/hazard_check.sv
hdl/unit_tracker.sv
hdl/issue_arbiter.sv
hdl/issue_scoreboard.sv
tb/tb_issue_scoreboard.sv
